//--- source/mem_op_pkg.sv
package mem_op_pkg;

    localparam int ADDR_W = 12;
    localparam int MEM_WORDS = 1024;

    // Loads first, stores after SB
    typedef enum logic [3:0] {
        LB, LBU, LH, LHU, LW, LWL, LWR,
        SB, SH, SW, SWL, SWR
    } mem_op_t;

    // Bus access size, TRI only comes out of SWL and SWR
    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,
        SZ_HALF = 2'b01,
        SZ_WORD = 2'b10,
        SZ_TRI  = 2'b11
    } acc_size_t;

    typedef enum logic [1:0] {
        UNAL_NONE  = 2'b00,
        UNAL_LEFT  = 2'b01,
        UNAL_RIGHT = 2'b10
    } unal_mode_t;

    typedef struct packed {
        mem_op_t           op;
        logic [ADDR_W-1:0] addr;
        // Store source register
        logic [31:0]       wdata;
        // Destination register before the load, for LWL and LWR
        logic [31:0]       old;
    } mem_req_t;

endpackage

//--- source/wb_pkg.sv
package wb_pkg;

    // Master to slave, classic cycle
    typedef struct packed {
        logic                          cyc;
        logic                          stb;
        logic                          we;
        // Word address
        logic [mem_op_pkg::ADDR_W-3:0] adr;
        logic [3:0]                    sel;
        logic [31:0]                   dat;
    } wb_m2s_t;

    // Slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_s2m_t;

endpackage

//--- source/store_align.sv
module store_align (
    input  mem_op_pkg::unal_mode_t store_mode,
    input  mem_op_pkg::unal_mode_t load_mode,
    input  mem_op_pkg::acc_size_t  size,
    input  logic [1:0]             offset,
    input  logic [31:0]            wdata,
    output logic [31:0]            aligned,
    output mem_op_pkg::acc_size_t  real_size,
    output logic [1:0]             real_offset
);
    import mem_op_pkg::*;

    logic [4:0] lane_shift;

    assign lane_shift = {offset, 3'b000};

    always_comb
    begin
        case (store_mode)
            UNAL_LEFT:
            begin
                // Top offset+1 bytes of the register go to the low lanes
                case (offset)
                    2'd0: aligned = {24'b0, wdata[31:24]};
                    2'd1: aligned = {16'b0, wdata[31:16]};
                    2'd2: aligned = {8'b0, wdata[31:8]};
                    2'd3: aligned = wdata;
                endcase
            end
            // Normal stores and SWR both shift up by the offset
            default:
                aligned = wdata << lane_shift;
        endcase
    end

    always_comb
    begin
        case (store_mode)
            UNAL_LEFT:
            begin
                case (offset)
                    2'd0: real_size = SZ_BYTE;
                    2'd1: real_size = SZ_HALF;
                    2'd2: real_size = SZ_TRI;
                    2'd3: real_size = SZ_WORD;
                endcase
            end
            UNAL_RIGHT:
            begin
                // Remaining bytes up to the end of the word
                case (offset)
                    2'd0: real_size = SZ_WORD;
                    2'd1: real_size = SZ_TRI;
                    2'd2: real_size = SZ_HALF;
                    2'd3: real_size = SZ_BYTE;
                endcase
            end
            default:
                real_size = size;
        endcase
    end

    // SWL writes from lane 0, LWL and LWR read the whole word
    assign real_offset = (store_mode == UNAL_LEFT || load_mode != UNAL_NONE) ? 2'b00 : offset;

endmodule

//--- source/load_merge.sv
module load_merge (
    input  mem_op_pkg::mem_op_t op,
    input  logic [1:0]          offset,
    input  logic [31:0]         rdata_word,
    input  logic [31:0]         old,
    output logic [31:0]         load_result
);
    import mem_op_pkg::*;

    logic [4:0]  shift_dn;
    logic [4:0]  shift_up;
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;
    logic [31:0] left_mask;
    logic [31:0] right_mask;
    logic [31:0] left_word;
    logic [31:0] right_word;

    // 8 times offset, and 8 times (3 - offset)
    assign shift_dn = {offset, 3'b000};
    assign shift_up = {~offset, 3'b000};

    assign lane_byte = 8'(rdata_word >> shift_dn);
    assign lane_half = offset[1] ? rdata_word[31:16] : rdata_word[15:0];

    // Lanes taken from memory, the rest come from old
    assign left_mask = 32'hffff_ffff << shift_up;
    assign right_mask = 32'hffff_ffff >> shift_dn;

    assign left_word = rdata_word << shift_up;
    assign right_word = rdata_word >> shift_dn;

    always_comb
    begin
        case (op)
            LB:
                load_result = {{24{lane_byte[7]}}, lane_byte};
            LBU:
                load_result = {24'b0, lane_byte};
            LH:
                load_result = {{16{lane_half[15]}}, lane_half};
            LHU:
                load_result = {16'b0, lane_half};
            LWL:
                load_result = (left_word & left_mask) | (old & ~left_mask);
            LWR:
                load_result = (right_word & right_mask) | (old & ~right_mask);
            // LW, and don't care for stores
            default:
                load_result = rdata_word;
        endcase
    end

endmodule

//--- source/wb_data_master.sv
module wb_data_master (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req_valid,
    input  mem_op_pkg::mem_req_t   req,
    output logic                   busy,
    output logic                   done,
    output logic [31:0]            rdata,
    output mem_op_pkg::unal_mode_t store_mode,
    output mem_op_pkg::unal_mode_t load_mode,
    output mem_op_pkg::acc_size_t  size,
    output logic [1:0]             offset,
    output logic [31:0]            wdata,
    output logic [31:0]            old,
    output mem_op_pkg::mem_op_t    op,
    input  logic [31:0]            aligned,
    input  mem_op_pkg::acc_size_t  real_size,
    input  logic [1:0]             real_offset,
    input  logic [31:0]            load_result,
    output wb_pkg::wb_m2s_t        wb_out,
    input  wb_pkg::wb_s2m_t        wb_in
);
    import mem_op_pkg::*;

    typedef enum logic [1:0] {IDLE, BUS, DONE} state_t;

    state_t     state;
    mem_req_t   req_q;
    logic       cyc;
    logic       is_store;
    logic       acked;
    logic [3:0] lane_mask;
    logic [3:0] sel;

    assign acked = cyc && wb_in.ack;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            cyc <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (req_valid)
                        state <= BUS;
                BUS:
                    if (acked)
                    begin
                        cyc <= 1'b0;
                        state <= DONE;
                    end
                    else
                        cyc <= 1'b1;
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == IDLE && req_valid)
            req_q <= req;
        // rdata keeps its value across stores
        if (state == BUS && acked && !is_store)
            rdata <= load_result;
    end

    always_comb
    begin
        size = SZ_WORD;
        store_mode = UNAL_NONE;
        load_mode = UNAL_NONE;
        is_store = 1'b0;
        case (req_q.op)
            LB, LBU:
                size = SZ_BYTE;
            LH, LHU:
                size = SZ_HALF;
            LWL:
                load_mode = UNAL_LEFT;
            LWR:
                load_mode = UNAL_RIGHT;
            SB:
            begin
                size = SZ_BYTE;
                is_store = 1'b1;
            end
            SH:
            begin
                size = SZ_HALF;
                is_store = 1'b1;
            end
            SWL:
            begin
                store_mode = UNAL_LEFT;
                is_store = 1'b1;
            end
            SWR:
            begin
                store_mode = UNAL_RIGHT;
                is_store = 1'b1;
            end
            SW:
                is_store = 1'b1;
            default:
                size = SZ_WORD;
        endcase
    end

    always_comb
    begin
        case (real_size)
            SZ_BYTE: lane_mask = 4'b0001;
            SZ_HALF: lane_mask = 4'b0011;
            SZ_TRI:  lane_mask = 4'b0111;
            default: lane_mask = 4'b1111;
        endcase
    end

    // Reads always fetch the full word
    assign sel = is_store ? 4'(lane_mask << real_offset) : 4'b1111;

    assign op = req_q.op;
    assign offset = req_q.addr[1:0];
    assign wdata = req_q.wdata;
    assign old = req_q.old;

    assign busy = state != IDLE;
    assign done = state == DONE;

    assign wb_out = '{
        cyc: cyc,
        stb: cyc,
        we:  cyc && is_store,
        adr: req_q.addr[ADDR_W-1:2],
        sel: sel,
        dat: aligned
    };

endmodule

//--- source/wb_byte_ram.sv
module wb_byte_ram (
    input  logic            clk,
    input  logic            reset,
    input  wb_pkg::wb_m2s_t wb_in,
    output wb_pkg::wb_s2m_t wb_out
);
    import mem_op_pkg::*;

    logic [31:0] mem [MEM_WORDS];
    logic        ack;
    logic [31:0] rdat;
    logic        access;

    // New strobe, the cycle that already got its ack is not served twice
    assign access = wb_in.cyc && wb_in.stb && !ack;

    always_ff @(posedge clk)
    begin
        if (reset)
            ack <= 1'b0;
        else
            ack <= access;
    end

    always_ff @(posedge clk)
    begin
        if (access)
        begin
            rdat <= mem[wb_in.adr[ADDR_W-3:0]];
            if (wb_in.we)
            begin
                for (int lane = 0; lane < 4; lane++)
                begin
                    if (wb_in.sel[lane])
                        mem[wb_in.adr][8*lane +: 8] <= wb_in.dat[8*lane +: 8];
                end
            end
        end
    end

    assign wb_out = '{ack: ack, dat: rdat};

endmodule

//--- source/mem_access_unit.sv
module mem_access_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req_valid,
    input  mem_op_pkg::mem_req_t req,
    output logic                 busy,
    output logic                 done,
    output logic [31:0]          rdata
);
    import mem_op_pkg::*;
    import wb_pkg::*;

    wb_m2s_t     wb_m2s;
    wb_s2m_t     wb_s2m;
    unal_mode_t  store_mode;
    unal_mode_t  load_mode;
    acc_size_t   size;
    acc_size_t   real_size;
    mem_op_t     op;
    logic [1:0]  offset;
    logic [1:0]  real_offset;
    logic [31:0] wdata;
    logic [31:0] old;
    logic [31:0] aligned;
    logic [31:0] load_result;

    wb_data_master u_master (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .busy        (busy),
        .done        (done),
        .rdata       (rdata),
        .store_mode  (store_mode),
        .load_mode   (load_mode),
        .size        (size),
        .offset      (offset),
        .wdata       (wdata),
        .old         (old),
        .op          (op),
        .aligned     (aligned),
        .real_size   (real_size),
        .real_offset (real_offset),
        .load_result (load_result),
        .wb_out      (wb_m2s),
        .wb_in       (wb_s2m)
    );

    store_align u_store_align (
        .store_mode  (store_mode),
        .load_mode   (load_mode),
        .size        (size),
        .offset      (offset),
        .wdata       (wdata),
        .aligned     (aligned),
        .real_size   (real_size),
        .real_offset (real_offset)
    );

    load_merge u_load_merge (
        .op          (op),
        .offset      (offset),
        .rdata_word  (wb_s2m.dat),
        .old         (old),
        .load_result (load_result)
    );

    wb_byte_ram u_ram (
        .clk    (clk),
        .reset  (reset),
        .wb_in  (wb_m2s),
        .wb_out (wb_s2m)
    );

endmodule

//--- sim/mem_access_asserts.sv
module mem_access_asserts (
    input logic            clk,
    input logic            reset,
    input logic            req_valid,
    input logic            busy,
    input logic            done,
    input wb_pkg::wb_m2s_t wb_out,
    input wb_pkg::wb_s2m_t wb_in
);
    timeunit 1ns;
    timeprecision 100ps;

    // The slave only answers a live strobe inside a bus cycle
    ack_inside_strobe: assert property (@(posedge clk) disable iff (reset)
        wb_in.ack |-> wb_out.cyc && wb_out.stb)
        else $error("Wishbone ack without an active strobe");

    // Address, lanes and direction hold until the slave answers
    hold_until_ack: assert property (@(posedge clk) disable iff (reset)
        wb_out.stb && !wb_in.ack |=> wb_out.stb && $stable(wb_out.adr)
            && $stable(wb_out.sel) && $stable(wb_out.we))
        else $error("Wishbone request changed or dropped before ack");

    ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_in.ack |=> !wb_in.ack)
        else $error("Wishbone ack held for more than one cycle");

    done_latency: assert property (@(posedge clk) disable iff (reset)
        req_valid && !busy |=> !done ##1 !done ##1 !done ##1 done)
        else $error("done not three cycles after the accepted request");

endmodule

bind wb_data_master mem_access_asserts u_asserts (.*);

//--- sim/tb_mem_access.sv
module tb_mem_access;
    timeunit 1ns;
    timeprecision 100ps;

    import mem_op_pkg::*;

    typedef struct packed {
        mem_op_t           op;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       wdata;
        logic [31:0]       old;
        // Load result, unused for stores
        logic [31:0]       expected;
    } vector_t;

    localparam int CLK_PERIOD = 4;
    localparam int DONE_WAIT = 8;
    localparam int NUM_VEC = 49;
    localparam int FILL_WORDS = 16;
    localparam int RANDOM_N = 200;
    // Eight cycles per access, one extra slot for reset
    localparam int WATCHDOG_NS = (NUM_VEC + FILL_WORDS + RANDOM_N + 1) * 8 * CLK_PERIOD;

    localparam vector_t VECTORS [NUM_VEC] = '{
        // Byte and half stores into one word
        '{SW,  12'h400, 32'h1122_3344, 32'h0, 32'h0},
        '{LW,  12'h400, 32'h0, 32'h0, 32'h1122_3344},
        '{SB,  12'h400, 32'h1234_56aa, 32'h0, 32'h0},
        '{LW,  12'h400, 32'h0, 32'h0, 32'h1122_33aa},
        '{SB,  12'h401, 32'h1234_56bb, 32'h0, 32'h0},
        '{LW,  12'h400, 32'h0, 32'h0, 32'h1122_bbaa},
        '{SB,  12'h402, 32'h9876_54cc, 32'h0, 32'h0},
        '{LW,  12'h400, 32'h0, 32'h0, 32'h11cc_bbaa},
        '{SB,  12'h403, 32'h0f0f_0fdd, 32'h0, 32'h0},
        '{LW,  12'h400, 32'h0, 32'h0, 32'hddcc_bbaa},
        '{SH,  12'h400, 32'h1234_eeff, 32'h0, 32'h0},
        '{LW,  12'h400, 32'h0, 32'h0, 32'hddcc_eeff},
        '{SH,  12'h402, 32'habcd_5566, 32'h0, 32'h0},
        '{LW,  12'h400, 32'h0, 32'h0, 32'h5566_eeff},
        // SWL fills lanes 0 to k
        '{SW,  12'h410, 32'h1122_3344, 32'h0, 32'h0},
        '{SWL, 12'h410, 32'ha0a1_a2a3, 32'h0, 32'h0},
        '{LW,  12'h410, 32'h0, 32'h0, 32'h1122_33a0},
        '{SWL, 12'h411, 32'hb0b1_b2b3, 32'h0, 32'h0},
        '{LW,  12'h410, 32'h0, 32'h0, 32'h1122_b0b1},
        '{SWL, 12'h412, 32'hc0c1_c2c3, 32'h0, 32'h0},
        '{LW,  12'h410, 32'h0, 32'h0, 32'h11c0_c1c2},
        '{SWL, 12'h413, 32'hd0d1_d2d3, 32'h0, 32'h0},
        '{LW,  12'h410, 32'h0, 32'h0, 32'hd0d1_d2d3},
        // SWR fills lanes k to 3
        '{SW,  12'h420, 32'h1122_3344, 32'h0, 32'h0},
        '{SWR, 12'h423, 32'ha0a1_a2a3, 32'h0, 32'h0},
        '{LW,  12'h420, 32'h0, 32'h0, 32'ha322_3344},
        '{SWR, 12'h422, 32'hb0b1_b2b3, 32'h0, 32'h0},
        '{LW,  12'h420, 32'h0, 32'h0, 32'hb2b3_3344},
        '{SWR, 12'h421, 32'hc0c1_c2c3, 32'h0, 32'h0},
        '{LW,  12'h420, 32'h0, 32'h0, 32'hc1c2_c344},
        '{SWR, 12'h420, 32'hd0d1_d2d3, 32'h0, 32'h0},
        '{LW,  12'h420, 32'h0, 32'h0, 32'hd0d1_d2d3},
        // Lanes with top bit set and clear
        '{SW,  12'h430, 32'h80ff_7f01, 32'h0, 32'h0},
        '{LB,  12'h431, 32'h0, 32'h0, 32'h0000_007f},
        '{LB,  12'h432, 32'h0, 32'h0, 32'hffff_ffff},
        '{LBU, 12'h430, 32'h0, 32'h0, 32'h0000_0001},
        '{LBU, 12'h433, 32'h0, 32'h0, 32'h0000_0080},
        '{LH,  12'h430, 32'h0, 32'h0, 32'h0000_7f01},
        '{LH,  12'h432, 32'h0, 32'h0, 32'hffff_80ff},
        '{LHU, 12'h430, 32'h0, 32'h0, 32'h0000_7f01},
        '{LHU, 12'h432, 32'h0, 32'h0, 32'h0000_80ff},
        '{LWL, 12'h430, 32'h0, 32'haabb_ccdd, 32'h01bb_ccdd},
        '{LWL, 12'h431, 32'h0, 32'haabb_ccdd, 32'h7f01_ccdd},
        '{LWL, 12'h432, 32'h0, 32'haabb_ccdd, 32'hff7f_01dd},
        '{LWL, 12'h433, 32'h0, 32'haabb_ccdd, 32'h80ff_7f01},
        '{LWR, 12'h430, 32'h0, 32'haabb_ccdd, 32'h80ff_7f01},
        '{LWR, 12'h431, 32'h0, 32'haabb_ccdd, 32'haa80_ff7f},
        '{LWR, 12'h432, 32'h0, 32'haabb_ccdd, 32'haabb_80ff},
        '{LWR, 12'h433, 32'h0, 32'haabb_ccdd, 32'haabb_cc80}
    };

    logic        clk;
    logic        reset;
    logic        req_valid;
    mem_req_t    req;
    logic        busy;
    logic        done;
    logic [31:0] rdata;

    // Byte-addressed reference memory
    logic [7:0]  model_mem [MEM_WORDS * 4];
    int          data_errors;
    int          timing_errors;

    mem_access_unit u_dut (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all accesses completed");
        $display("Test FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] fill_word(input logic [ADDR_W-1:0] a);
        return {a, 8'h5a, ~a};
    endfunction

    function automatic logic is_load(input mem_op_t op);
        return op inside {LB, LBU, LH, LHU, LW, LWL, LWR};
    endfunction

    function automatic string describe(input mem_req_t r);
        return $sformatf("%s at 0x%03h", r.op.name(), r.addr);
    endfunction

    // Applies one access to the byte model and returns the load result
    function automatic logic [31:0] model_access(input mem_req_t r);
        logic [31:0]       res;
        logic [ADDR_W-1:0] base;
        int                k;
        res = r.old;
        base = {r.addr[ADDR_W-1:2], 2'b00};
        k = r.addr[1:0];
        case (r.op)
            SB:
                model_mem[r.addr] = r.wdata[7:0];
            SH:
                for (int i = 0; i < 2; i++)
                    model_mem[r.addr + i] = r.wdata[8*i +: 8];
            SW:
                for (int i = 0; i < 4; i++)
                    model_mem[base + i] = r.wdata[8*i +: 8];
            SWL:
                for (int i = 0; i <= k; i++)
                    model_mem[base + i] = r.wdata[8*(3-k+i) +: 8];
            SWR:
                for (int i = k; i < 4; i++)
                    model_mem[base + i] = r.wdata[8*(i-k) +: 8];
            LB:
                res = {{24{model_mem[r.addr][7]}}, model_mem[r.addr]};
            LBU:
                res = {24'b0, model_mem[r.addr]};
            LH:
                res = {{16{model_mem[r.addr + 1][7]}}, model_mem[r.addr + 1], model_mem[r.addr]};
            LHU:
                res = {16'b0, model_mem[r.addr + 1], model_mem[r.addr]};
            LW:
                for (int i = 0; i < 4; i++)
                    res[8*i +: 8] = model_mem[base + i];
            LWL:
                for (int i = 0; i <= k; i++)
                    res[8*(3-k+i) +: 8] = model_mem[base + i];
            LWR:
                for (int i = 0; i <= 3 - k; i++)
                    res[8*i +: 8] = model_mem[base + k + i];
            default:
                res = r.old;
        endcase
        return res;
    endfunction

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp)
        begin
            data_errors++;
            $display("[ERROR] rdata after %s: expected 0x%08h, got 0x%08h", what, exp, got);
        end
    endtask

    // Called 0.5 ns after a rising edge with the DUT idle
    task automatic run_access(input mem_req_t r, output logic [31:0] result);
        int cycles;
        req = r;
        req_valid = 1'b1;
        @(posedge clk);
        #0.5;
        req_valid = 1'b0;
        cycles = 0;
        while (!done && cycles < DONE_WAIT)
        begin
            if (!busy)
            begin
                timing_errors++;
                $display("busy was low before done for %s", describe(r));
            end
            @(posedge clk);
            #0.5;
            cycles++;
        end
        if (!done)
        begin
            timing_errors++;
            $display("No done within %0d cycles for %s", DONE_WAIT, describe(r));
        end
        else if (cycles != 3)
        begin
            timing_errors++;
            $display("[ERROR] done latency: expected 0x3, got 0x%0h", cycles);
        end
        result = rdata;
        @(posedge clk);
        #0.5;
        if (done || busy)
        begin
            timing_errors++;
            $display("busy or done still high one cycle after done for %s", describe(r));
        end
    endtask

    task automatic apply(input mem_req_t r, input logic [31:0] load_exp);
        logic [31:0] prev_rdata;
        logic [31:0] got;
        prev_rdata = rdata;
        run_access(r, got);
        if (is_load(r.op))
            check_word(describe(r), load_exp, got);
        else
            check_word(describe(r), prev_rdata, got);
    endtask

    initial
    begin
        mem_req_t    r;
        logic [31:0] rng;
        clk = 1'b0;
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        data_errors = 0;
        timing_errors = 0;
        rng = 32'h5c7a5adf;
        repeat (4) @(posedge clk);
        #0.5;
        reset = 1'b0;
        if (busy || done)
        begin
            timing_errors++;
            $display("busy or done is high right after reset");
        end

        foreach (VECTORS[i])
        begin
            r.op = VECTORS[i].op;
            r.addr = VECTORS[i].addr;
            r.wdata = VECTORS[i].wdata;
            r.old = VECTORS[i].old;
            void'(model_access(r));
            apply(r, VECTORS[i].expected);
        end

        // Known contents for the random window
        for (int w = 0; w < FILL_WORDS; w++)
        begin
            r.op = SW;
            r.addr = ADDR_W'(4 * w);
            r.wdata = fill_word(r.addr);
            r.old = '0;
            apply(r, model_access(r));
        end

        for (int n = 0; n < RANDOM_N; n++)
        begin
            rng = xorshift32(rng);
            r.op = mem_op_t'(4'(rng % 32'd12));
            rng = xorshift32(rng);
            r.addr = ADDR_W'(rng % (FILL_WORDS * 4));
            if (r.op inside {LH, LHU, SH})
                r.addr[0] = 1'b0;
            if (r.op inside {LW, SW})
                r.addr[1:0] = 2'b00;
            rng = xorshift32(rng);
            r.wdata = rng;
            rng = xorshift32(rng);
            r.old = rng;
            apply(r, model_access(r));
        end

        $display("Errors: %0d data, %0d timing", data_errors, timing_errors);
        if (data_errors == 0 && timing_errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- compile.f
source/mem_op_pkg.sv
source/wb_pkg.sv
source/store_align.sv
source/load_merge.sv
source/wb_data_master.sv
source/wb_byte_ram.sv
source/mem_access_unit.sv
sim/mem_access_asserts.sv
sim/tb_mem_access.sv

//--- Bender.yml
package:
  name: mem_access_unit

sources:
  - source/mem_op_pkg.sv
  - source/wb_pkg.sv
  - source/store_align.sv
  - source/load_merge.sv
  - source/wb_data_master.sv
  - source/wb_byte_ram.sv
  - source/mem_access_unit.sv
  - target: simulation
    files:
      - sim/mem_access_asserts.sv
      - sim/tb_mem_access.sv
